// File: build.f
src/bus_types_pkg.sv
src/soc_map_pkg.sv
src/dev_bus_if.sv
src/wb_decoder.sv
src/ram_sp.sv
src/gpio_regs.sv
src/mtimer.sv
src/soc_periph_top.sv
dv/tb_soc_periph.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_soc_periph
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)
LINTFLAGS := --lint-only -Wall --timing --top-module $(TOP)
PASS_MSG  := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_soc_periph.sv
// Peripheral subsystem testbench
`timescale 1ns/1ps

module tb_soc_periph;
  import bus_types_pkg::*;
  import soc_map_pkg::*;

  localparam int unsigned Seed       = 32'h43cd69ac;
  localparam int          ClkHalf    = 50;
  localparam int          DriveDelay = 10;
  localparam int          RamWrites  = 200;
  localparam int          UnmappedTries = 23;
  // Transfers of each test section in run order.
  localparam int          Transfers  = 1 + RamWrites + RamWrites / 2 + 8 * 2 + 4
                                       + UnmappedTries * 3 + 6 + 6;
  localparam int          WatchdogCycles = 2 * (Transfers * 2 + 2000);

  logic        clk_sys = 1'b0;
  logic        rst_sys_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  addr_t       wb_adr;
  be_t         wb_sel;
  data_t       wb_dat_w;
  data_t       wb_dat_r;
  logic        wb_ack;
  logic        wb_err;
  gpi_t        gp_in;
  gpo_t        gp_out;
  logic        timer_irq;

  // Reference state.
  data_t       ref_mem [RamWords];
  be_t         ref_known [RamWords]; // Lanes written so far.
  gpo_t        ref_gpo;
  gpi_t        ref_gpi;
  word_idx_t   written_q [$];

  dev_sel_e    exp_kind;
  data_t       exp_data;
  data_t       exp_mask;
  int unsigned cycle_cnt = 0;
  int unsigned ack_cycle;

  always #(ClkHalf) clk_sys = ~clk_sys;

  always @(posedge clk_sys) cycle_cnt <= cycle_cnt + 1;

  soc_periph_top u_soc_periph_top (
    .clk_sys_i  (clk_sys),
    .rst_sys_ni (rst_sys_n),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .wb_we_i    (wb_we),
    .wb_adr_i   (wb_adr),
    .wb_sel_i   (wb_sel),
    .wb_dat_i   (wb_dat_w),
    .wb_dat_o   (wb_dat_r),
    .wb_ack_o   (wb_ack),
    .wb_err_o   (wb_err),
    .gp_i       (gp_in),
    .gp_o       (gp_out),
    .timer_irq_o(timer_irq)
  );

  function automatic addr_t reg_addr(input addr_t base, input reg_off_t off);
    return base + addr_t'(off);
  endfunction

  function automatic addr_t ram_addr(input word_idx_t idx);
    return RamStart + {20'h0, idx, 2'b00};
  endfunction

  function automatic word_idx_t ram_index(input addr_t adr);
    return word_idx_t'((adr - RamStart) >> 2);
  endfunction

  function automatic data_t lanes_to_mask(input be_t lanes);
    data_t m;
    m = '0;
    for (int i = 0; i < $bits(be_t); i++) begin
      if (lanes[i]) m[i*8 +: 8] = 8'hff;
    end
    return m;
  endfunction

  // Window ranges straight from the address map.
  function automatic dev_sel_e expected_kind(input addr_t adr);
    if (adr >= RamStart && adr < RamStart + RamSize) return dev_ram;
    if (adr >= GpioStart && adr < GpioStart + GpioSize) return dev_gpio;
    if (adr >= TimerStart && adr < TimerStart + TimerSize) return dev_timer;
    return dev_none;
  endfunction

  function automatic data_t ref_read(input addr_t adr, output dev_sel_e kind);
    reg_off_t off;
    data_t    res;
    kind = expected_kind(adr);
    off  = reg_off_t'(adr - GpioStart);
    res  = '0;
    case (kind)
      dev_ram: res = ref_mem[ram_index(adr)];
      dev_gpio: begin
        if (off == GpioOutOff) res = {16'h0, ref_gpo};
        else if (off == GpioInOff) res = {24'h0, ref_gpi};
      end
      default: res = '0; // Timer values are checked by their own rules.
    endcase
    return res;
  endfunction

  function automatic data_t known_mask(input addr_t adr);
    case (expected_kind(adr))
      dev_ram:  return lanes_to_mask(ref_known[ram_index(adr)]);
      dev_none: return '0;
      default:  return '1;
    endcase
  endfunction

  task automatic ref_write(input addr_t adr, input be_t sel, input data_t wdat);
    dev_sel_e kind;
    data_t    old_w;
    data_t    m;
    old_w = ref_read(adr, kind);
    m     = lanes_to_mask(sel);
    if (kind == dev_ram) begin
      ref_mem[ram_index(adr)]   = (old_w & ~m) | (wdat & m);
      ref_known[ram_index(adr)] = ref_known[ram_index(adr)] | sel;
    end else if (kind == dev_gpio && reg_off_t'(adr - GpioStart) == GpioOutOff) begin
      ref_gpo = gpo_t'((data_t'(ref_gpo) & ~m) | (wdat & m)); // Upper lanes dropped.
    end
  endtask

  task automatic report_failure(input string line);
    $display("Something failed");
    $display("%s", line);
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_gpo(input string name, input gpo_t got, input gpo_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_irq(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t ns: %s is %b, expected %b",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input dev_sel_e kind,
                            input logic got_ack, input logic got_err);
    logic exp_ack;
    logic exp_err;
    exp_ack = (kind != dev_none);
    exp_err = !exp_ack;
    if (got_ack !== exp_ack || got_err !== exp_err) begin
      report_failure($sformatf("mismatch at %0t ns: %s ack/err is %b/%b, expected %b/%b (%s)",
                               $time, name, got_ack, got_err, exp_ack, exp_err, kind.name()));
    end
  endtask

  // Checks every ack or err response.
  always @(negedge clk_sys) begin
    if (rst_sys_n && (wb_ack || wb_err)) begin
      check_resp("wb response", exp_kind, wb_ack, wb_err);
      check_data("wb_dat_o", wb_dat_r & exp_mask, exp_data);
    end
  end

  task automatic wb_access(input logic we, input addr_t adr, input be_t sel,
                           input data_t wdat, input logic check_rd, output data_t rdat);
    dev_sel_e kind;
    data_t    exp_d;
    exp_d = ref_read(adr, kind);
    @(posedge clk_sys);
    #(DriveDelay);
    exp_kind = kind;
    exp_mask = (we || !check_rd) ? '0 : known_mask(adr);
    exp_data = exp_d & exp_mask;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_sel   = sel;
    wb_dat_w = wdat;
    @(negedge clk_sys);
    while (!(wb_ack || wb_err)) @(negedge clk_sys);
    rdat      = wb_dat_r;
    ack_cycle = cycle_cnt;
    @(posedge clk_sys);
    #(DriveDelay);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (we) ref_write(adr, sel, wdat);
  endtask

  task automatic wait_until_cycle(input int unsigned target);
    while (cycle_cnt < target) @(negedge clk_sys);
  endtask

  initial begin
    repeat (WatchdogCycles) @(posedge clk_sys);
    report_failure($sformatf("timeout, tests did not finish within %0d cycles",
                             WatchdogCycles));
  end

  initial begin
    data_t       rd;
    data_t       rd2;
    addr_t       adr;
    word_idx_t   idx;
    int unsigned c0;
    addr_t       edge_adr [3];
    void'($urandom(Seed));
    rst_sys_n = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_sel    = '0;
    wb_dat_w  = '0;
    gp_in     = '0;
    ref_gpo   = '0;
    ref_gpi   = '0;
    exp_kind  = dev_none;
    exp_data  = '0;
    exp_mask  = '0;
    for (int i = 0; i < RamWords; i++) begin
      ref_mem[i]   = '0;
      ref_known[i] = '0;
    end
    repeat (3) @(posedge clk_sys);
    #(DriveDelay);
    rst_sys_n = 1'b1;

    // State right after reset.
    @(negedge clk_sys);
    check_irq("wb_ack_o", wb_ack, 1'b0);
    check_irq("wb_err_o", wb_err, 1'b0);
    check_irq("timer_irq_o", timer_irq, 1'b0);
    check_gpo("gp_o", gp_out, '0);
    wb_access(1'b0, reg_addr(TimerStart, MtimecmpLoOff), 4'hF, '0, 1'b0, rd);
    check_data("mtimecmp low", rd, 32'hffff_ffff);

    // RAM writes with random lanes and reads of written words.
    for (int i = 0; i < RamWrites; i++) begin
      idx = word_idx_t'($urandom % RamWords);
      wb_access(1'b1, ram_addr(idx), be_t'($urandom), $urandom, 1'b0, rd);
      written_q.push_back(idx);
      if (i % 2 == 1) begin
        idx = written_q[$urandom % written_q.size()];
        wb_access(1'b0, ram_addr(idx), 4'hF, '0, 1'b1, rd);
      end
    end

    // GPIO output register and input synchronizer.
    for (int i = 0; i < 8; i++) begin
      wb_access(1'b1, reg_addr(GpioStart, GpioOutOff), be_t'($urandom), $urandom, 1'b0, rd);
      check_gpo("gp_o", gp_out, ref_gpo);
      wb_access(1'b0, reg_addr(GpioStart, GpioOutOff), 4'hF, '0, 1'b1, rd);
    end
    for (int i = 0; i < 4; i++) begin
      gp_in   = gpi_t'($urandom);
      ref_gpi = gp_in;
      repeat (3) @(posedge clk_sys);
      wb_access(1'b0, reg_addr(GpioStart, GpioInOff), 4'hF, '0, 1'b1, rd);
    end

    // Unmapped addresses at window edges and at random.
    edge_adr[0] = RamStart + RamSize;
    edge_adr[1] = GpioStart + GpioSize;
    edge_adr[2] = TimerStart - 32'd4;
    for (int i = 0; i < UnmappedTries; i++) begin
      if (i < 3) begin
        adr = edge_adr[i];
      end else begin
        do adr = $urandom; while (expected_kind(adr) != dev_none);
      end
      idx = ram_index(adr); // RAM word hit by the same low address bits.
      wb_access(1'b1, ram_addr(idx), 4'hF, $urandom, 1'b0, rd);
      wb_access(i % 2 == 0, adr, 4'hF, $urandom, 1'b1, rd);
      wb_access(1'b0, ram_addr(idx), 4'hF, '0, 1'b1, rd);
    end

    // mtime counting.
    wb_access(1'b0, reg_addr(TimerStart, MtimeLoOff), 4'hF, '0, 1'b0, rd);
    wb_access(1'b0, reg_addr(TimerStart, MtimeLoOff), 4'hF, '0, 1'b0, rd2);
    if (!(rd2 > rd)) begin
      report_failure($sformatf("mtime did not increase between two reads (%0d, then %0d)",
                               rd, rd2));
    end
    wb_access(1'b1, reg_addr(TimerStart, MtimeHiOff), 4'hF, '0, 1'b0, rd);
    wb_access(1'b1, reg_addr(TimerStart, MtimeLoOff), 4'hF, '0, 1'b0, rd);
    c0 = ack_cycle;
    wb_access(1'b0, reg_addr(GpioStart, GpioOutOff), 4'hF, '0, 1'b1, rd);
    wb_access(1'b0, reg_addr(TimerStart, MtimeLoOff), 4'hF, '0, 1'b0, rd);
    if (rd > data_t'(ack_cycle - c0)) begin
      report_failure($sformatf("mtime read %0d is larger than the %0d cycles since it was cleared",
                               rd, ack_cycle - c0));
    end

    // Timer interrupt at mtimecmp = 100.
    wb_access(1'b1, reg_addr(TimerStart, MtimeHiOff), 4'hF, '0, 1'b0, rd);
    wb_access(1'b1, reg_addr(TimerStart, MtimeLoOff), 4'hF, '0, 1'b0, rd);
    c0 = ack_cycle;
    wb_access(1'b1, reg_addr(TimerStart, MtimecmpHiOff), 4'hF, '0, 1'b0, rd);
    wb_access(1'b1, reg_addr(TimerStart, MtimecmpLoOff), 4'hF, 32'd100, 1'b0, rd);
    wait_until_cycle(c0 + 50);
    check_irq("timer_irq_o", timer_irq, 1'b0);
    wait_until_cycle(c0 + 110);
    check_irq("timer_irq_o", timer_irq, 1'b1);
    wb_access(1'b1, reg_addr(TimerStart, MtimecmpHiOff), 4'hF, 32'hffff_ffff, 1'b0, rd);
    wb_access(1'b1, reg_addr(TimerStart, MtimecmpLoOff), 4'hF, 32'hffff_ffff, 1'b0, rd);
    @(negedge clk_sys);
    check_irq("timer_irq_o", timer_irq, 1'b0);

    $display("Everything OK");
    $finish;
  end

endmodule

// File: src/soc_periph_top.sv
// Peripheral subsystem top
`timescale 1ns/1ps

module soc_periph_top (
  input  logic                 clk_sys_i,
  input  logic                 rst_sys_ni,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  bus_types_pkg::addr_t wb_adr_i,
  input  bus_types_pkg::be_t   wb_sel_i,
  input  bus_types_pkg::data_t wb_dat_i,
  output bus_types_pkg::data_t wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,
  input  soc_map_pkg::gpi_t    gp_i,
  output soc_map_pkg::gpo_t    gp_o,
  output logic                 timer_irq_o
);

  // One device bus per peripheral.
  dev_bus_if ram_bus ();
  dev_bus_if gpio_bus ();
  dev_bus_if timer_bus ();

  wb_decoder u_wb_decoder (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_sel_i  (wb_sel_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .wb_err_o  (wb_err_o),
    .ram_bus   (ram_bus.host),
    .gpio_bus  (gpio_bus.host),
    .timer_bus (timer_bus.host)
  );

  ram_sp u_ram (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .bus       (ram_bus.device)
  );

  gpio_regs u_gpio (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .bus       (gpio_bus.device),
    .gp_i      (gp_i),
    .gp_o      (gp_o)
  );

  mtimer u_timer (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .bus        (timer_bus.device),
    .timer_irq_o(timer_irq_o)
  );

endmodule

// File: src/mtimer.sv
// Machine timer
`timescale 1ns/1ps

module mtimer (
  input  logic       clk_sys_i,
  input  logic       rst_sys_ni,
  dev_bus_if.device  bus,
  output logic       timer_irq_o
);
  import bus_types_pkg::*;
  import soc_map_pkg::*;

  reg_off_t off;
  logic     wr_en;
  mtime_t   mtime_q;
  mtime_t   mtime_d;
  mtime_t   mtimecmp_q;
  mtime_t   mtimecmp_d;
  data_t    rdata_q;
  logic     rvalid_q;
  logic     irq_q;

  // Replace only the enabled byte lanes.
  function automatic data_t merge_be(data_t old_w, data_t new_w, be_t be);
    data_t res;
    res = old_w;
    for (int i = 0; i < $bits(be_t); i++) begin
      if (be[i]) begin
        res[i*8 +: 8] = new_w[i*8 +: 8];
      end
    end
    return res;
  endfunction

  assign off   = bus.addr[$bits(reg_off_t)-1:0];
  assign wr_en = bus.req && bus.we;

  always_comb begin
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    if (wr_en) begin
      case (off)
        MtimeLoOff: mtime_d = {mtime_q[63:32], merge_be(mtime_q[31:0], bus.wdata, bus.be)};
        MtimeHiOff: mtime_d = {merge_be(mtime_q[63:32], bus.wdata, bus.be), mtime_q[31:0]};
        MtimecmpLoOff: begin
          mtimecmp_d = {mtimecmp_q[63:32], merge_be(mtimecmp_q[31:0], bus.wdata, bus.be)};
        end
        MtimecmpHiOff: begin
          mtimecmp_d = {merge_be(mtimecmp_q[63:32], bus.wdata, bus.be), mtimecmp_q[31:0]};
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1; // Far future so no interrupt.
      irq_q      <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      irq_q      <= (mtime_q >= mtimecmp_q);
      rvalid_q   <= bus.req;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus.req) begin
      case (off)
        MtimeLoOff:    rdata_q <= mtime_q[31:0];
        MtimeHiOff:    rdata_q <= mtime_q[63:32];
        MtimecmpLoOff: rdata_q <= mtimecmp_q[31:0];
        MtimecmpHiOff: rdata_q <= mtimecmp_q[63:32];
        default:       rdata_q <= '0;
      endcase
    end
  end

  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign timer_irq_o = irq_q;

endmodule

// File: src/gpio_regs.sv
// GPIO registers
`timescale 1ns/1ps

module gpio_regs (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,
  dev_bus_if.device           bus,
  input  soc_map_pkg::gpi_t   gp_i,
  output soc_map_pkg::gpo_t   gp_o
);
  import bus_types_pkg::*;
  import soc_map_pkg::*;

  reg_off_t off;
  gpi_t     gp_sync1_q;
  gpi_t     gp_sync2_q;
  gpo_t     gpo_q;
  data_t    rdata_q;
  logic     rvalid_q;

  assign off = bus.addr[$bits(reg_off_t)-1:0];

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_sync1_q <= '0;
      gp_sync2_q <= '0;
      gpo_q      <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      gp_sync1_q <= gp_i;
      gp_sync2_q <= gp_sync1_q;
      rvalid_q   <= bus.req;
      if (bus.req && bus.we && (off == GpioOutOff)) begin
        for (int i = 0; i < $bits(gpo_t) / 8; i++) begin
          if (bus.be[i]) begin
            gpo_q[i*8 +: 8] <= bus.wdata[i*8 +: 8]; // Upper lanes dropped.
          end
        end
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus.req) begin
      case (off)
        GpioOutOff: rdata_q <= data_t'(gpo_q);
        GpioInOff:  rdata_q <= data_t'(gp_sync2_q);
        default:    rdata_q <= '0;
      endcase
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign gp_o       = gpo_q;

endmodule

// File: src/ram_sp.sv
// Single-port data RAM
`timescale 1ns/1ps

module ram_sp (
  input  logic       clk_sys_i,
  input  logic       rst_sys_ni,
  dev_bus_if.device  bus
);
  import bus_types_pkg::*;

  data_t     mem [RamWords];
  word_idx_t word_idx;
  data_t     rdata_q;
  logic      rvalid_q;

  // Word index sits above the byte offset.
  assign word_idx = bus.addr[$bits(word_idx_t)+1:2];

  always_ff @(posedge clk_sys_i) begin
    if (bus.req && bus.we) begin
      for (int i = 0; i < $bits(be_t); i++) begin
        if (bus.be[i]) begin
          mem[word_idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus.req && !bus.we) begin
      rdata_q <= mem[word_idx];
    end
  end

  // Writes are answered as well.
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

endmodule

// File: src/wb_decoder.sv
// Wishbone slave and address decoder
`timescale 1ns/1ps

module wb_decoder (
  input  logic                 clk_sys_i,
  input  logic                 rst_sys_ni,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  bus_types_pkg::addr_t wb_adr_i,
  input  bus_types_pkg::be_t   wb_sel_i,
  input  bus_types_pkg::data_t wb_dat_i,
  output bus_types_pkg::data_t wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,
  dev_bus_if.host              ram_bus,
  dev_bus_if.host              gpio_bus,
  dev_bus_if.host              timer_bus
);
  import soc_map_pkg::*;

  typedef enum logic {
    st_idle,
    st_wait
  } state_e;

  state_e   state_q;
  dev_sel_e dev_sel;
  dev_sel_e sel_q;
  logic     start;

  always_comb begin
    if ((wb_adr_i & RamMask) == RamStart) begin
      dev_sel = dev_ram;
    end else if ((wb_adr_i & GpioMask) == GpioStart) begin
      dev_sel = dev_gpio;
    end else if ((wb_adr_i & TimerMask) == TimerStart) begin
      dev_sel = dev_timer;
    end else begin
      dev_sel = dev_none;
    end
  end

  assign start = (state_q == st_idle) && wb_cyc_i && wb_stb_i; // New transfer seen.

  assign ram_bus.req   = start && (dev_sel == dev_ram);
  assign gpio_bus.req  = start && (dev_sel == dev_gpio);
  assign timer_bus.req = start && (dev_sel == dev_timer);

  // Request fields go to every device. Only req is routed.
  assign ram_bus.we      = wb_we_i;
  assign ram_bus.be      = wb_sel_i;
  assign ram_bus.addr    = wb_adr_i;
  assign ram_bus.wdata   = wb_dat_i;
  assign gpio_bus.we     = wb_we_i;
  assign gpio_bus.be     = wb_sel_i;
  assign gpio_bus.addr   = wb_adr_i;
  assign gpio_bus.wdata  = wb_dat_i;
  assign timer_bus.we    = wb_we_i;
  assign timer_bus.be    = wb_sel_i;
  assign timer_bus.addr  = wb_adr_i;
  assign timer_bus.wdata = wb_dat_i;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      state_q <= st_idle;
      sel_q   <= dev_none;
    end else if (start) begin
      state_q <= st_wait;
      sel_q   <= dev_sel;
    end else begin
      state_q <= st_idle; // Response cycle always lasts one cycle.
    end
  end

  always_comb begin
    wb_ack_o = 1'b0;
    wb_dat_o = '0;
    if (state_q == st_wait) begin
      case (sel_q)
        dev_ram: begin
          wb_ack_o = ram_bus.rvalid;
          wb_dat_o = ram_bus.rdata;
        end
        dev_gpio: begin
          wb_ack_o = gpio_bus.rvalid;
          wb_dat_o = gpio_bus.rdata;
        end
        dev_timer: begin
          wb_ack_o = timer_bus.rvalid;
          wb_dat_o = timer_bus.rdata;
        end
        default: ;
      endcase
    end
  end

  assign wb_err_o = (state_q == st_wait) && (sel_q == dev_none);

endmodule

// File: src/dev_bus_if.sv
// Device request and response bus
`timescale 1ns/1ps

interface dev_bus_if;
  import bus_types_pkg::*;

  logic  req;   // One cycle per access.
  logic  we;
  be_t   be;
  addr_t addr;
  data_t wdata;
  logic  rvalid; // Follows req by one cycle.
  data_t rdata;

  modport host (
    output req,
    output we,
    output be,
    output addr,
    output wdata,
    input  rvalid,
    input  rdata
  );

  modport device (
    input  req,
    input  we,
    input  be,
    input  addr,
    input  wdata,
    output rvalid,
    output rdata
  );

endinterface

// File: src/soc_map_pkg.sv
// Peripheral address map

package soc_map_pkg;

  // Device windows, each aligned to its size.
  localparam bus_types_pkg::addr_t RamStart   = 32'h0010_0000;
  localparam bus_types_pkg::addr_t RamSize    = 32'h0000_1000; // 4 KiB.
  localparam bus_types_pkg::addr_t RamMask    = ~(RamSize - 32'd1);

  localparam bus_types_pkg::addr_t GpioStart  = 32'h8000_0000;
  localparam bus_types_pkg::addr_t GpioSize   = 32'h0000_1000; // 4 KiB.
  localparam bus_types_pkg::addr_t GpioMask   = ~(GpioSize - 32'd1);

  localparam bus_types_pkg::addr_t TimerStart = 32'h8000_2000;
  localparam bus_types_pkg::addr_t TimerSize  = 32'h0000_1000; // 4 KiB.
  localparam bus_types_pkg::addr_t TimerMask  = ~(TimerSize - 32'd1);

  typedef enum logic [1:0] {
    dev_ram,
    dev_gpio,
    dev_timer,
    dev_none
  } dev_sel_e;

  // Register offset inside a 4 KiB peripheral window.
  typedef logic [11:0] reg_off_t;

  localparam reg_off_t GpioOutOff    = 12'h000;
  localparam reg_off_t GpioInOff     = 12'h004;

  localparam reg_off_t MtimeLoOff    = 12'h000;
  localparam reg_off_t MtimeHiOff    = 12'h004;
  localparam reg_off_t MtimecmpLoOff = 12'h008;
  localparam reg_off_t MtimecmpHiOff = 12'h00C;

  typedef logic [7:0]  gpi_t;
  typedef logic [15:0] gpo_t;
  typedef logic [63:0] mtime_t;

endpackage

// File: src/bus_types_pkg.sv
// Bus widths and vector types

package bus_types_pkg;

  // Byte address and data word of the device bus.
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // One enable per byte lane.
  typedef logic [3:0] be_t;

  // RAM holds 4 KiB of 32-bit words.
  localparam int unsigned RamWords = 1024;

  typedef logic [9:0] word_idx_t;

endpackage
